//--- sources.f
design/trig_pkg.sv
design/acq_pkg.sv
design/acq_if.sv
design/ttc_trigger_receiver.sv
design/acq_delay_timer.sv
design/channel_acq_controller.sv
design/acq_event_fifo.sv
design/trigger_top.sv
verif/tb_trigger_top.sv

//--- Makefile
# Verilator build and run of the trigger path testbench

VERILATOR ?= verilator
TOP       ?= tb_trigger_top
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sources.f --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_trigger_top.sv
// single ttc_clk testbench; done lines answer 1 to 8 cycles after chan_trig, delays up to 20
`timescale 1ns/100ps

module tb_trigger_top
    import trig_pkg::*;
    import acq_pkg::*;
();

    localparam int CLK_HALF       = 4;  // 8 ns period
    localparam int RESET_CYC      = 10;
    localparam int MAX_DELAY      = 20;
    localparam int WAIT_LIMIT     = 200; // cycles per handshake wait
    localparam int TRIG_WORST_CYC = 64;  // ready wait, delay, done latency, sync and write
    localparam int N_TRIGS        = 5 + 40 + 3 + 2 + FIFO_AF_LEVEL + 1;
    localparam int WATCHDOG_CYC   = RESET_CYC + N_TRIGS * TRIG_WORST_CYC + 1000;

    logic                   ttc_clk = 1'b0;
    logic                   arst_n;
    logic                   ttc_trigger;
    logic [TRIG_TYPE_W-1:0] trig_type;
    logic                   rst_trigger_num;
    logic                   rst_trigger_timestamp;
    logic [N_CHAN-1:0]      chan_en;
    logic [DELAY_W-1:0]     trig_delay;
    logic [N_CHAN-1:0]      chan_dones = '0; // owned by the channel model
    logic                   event_ready;
    logic [N_CHAN-1:0]      chan_enable;
    logic [N_CHAN-1:0]      chan_trig;
    logic [TRIG_NUM_W-1:0]  trig_num;
    logic [TIMESTAMP_W-1:0] trig_timestamp;
    logic                   acq_ready;
    logic                   error_trig_rate;
    logic                   event_valid;
    logic [EVENT_W-1:0]     event_data;
    logic                   fifo_almost_full;
    logic [CAC_STATE_W-1:0] cac_state;

    logic [31:0]           lfsr_state = 32'h292b_58a2;
    logic [EVENT_W-1:0]    exp_q [$];      // expected event words in fifo order
    logic [TRIG_NUM_W-1:0] exp_num = '0;   // model of the trigger number
    longint                cyc = 0;        // rising edges since time zero
    longint                trig_cyc = 0;   // edge of the last accepted trigger
    int                    done_wait [N_CHAN] = '{default: 0};
    int                    test_delays [5] = '{0, 1, 2, 5, 13};
    int                    err_cnt = 0;
    int                    chk_cnt = 0;
    int                    test_no = 0;
    int                    tests_failed = 0;
    int                    test_err0 = 0;

    trigger_top i_trigger_top (
        .ttc_clk               (ttc_clk),
        .arst_n                (arst_n),
        .ttc_trigger           (ttc_trigger),
        .trig_type             (trig_type),
        .rst_trigger_num       (rst_trigger_num),
        .rst_trigger_timestamp (rst_trigger_timestamp),
        .chan_en               (chan_en),
        .trig_delay            (trig_delay),
        .chan_dones            (chan_dones),
        .event_ready           (event_ready),
        .chan_enable           (chan_enable),
        .chan_trig             (chan_trig),
        .trig_num              (trig_num),
        .trig_timestamp        (trig_timestamp),
        .acq_ready             (acq_ready),
        .error_trig_rate       (error_trig_rate),
        .event_valid           (event_valid),
        .event_data            (event_data),
        .fifo_almost_full      (fifo_almost_full),
        .cac_state             (cac_state)
    );

    always #(CLK_HALF) ttc_clk = ~ttc_clk;

    always @(posedge ttc_clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------------------
    // random source, expected values and checks
    // ------------------------------------------------------------------------

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // event word: reserved 31:29 zero, type 28:24, number 23:0
    function automatic logic [EVENT_W-1:0] expected_event(input logic [TRIG_NUM_W-1:0] num,
                                                          input logic [TRIG_TYPE_W-1:0] ttype);
        return {3'b000, ttype, num};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        chk_cnt++;
        assert (cond) else begin
            $display("%s at %0t", what, $time);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (err_cnt == test_err0) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            $display("test %0d %s: %0d errors", test_no, name, err_cnt - test_err0);
            tests_failed++;
        end
        test_err0 = err_cnt;
    endtask

    // ------------------------------------------------------------------------
    // handshake helpers, all return on a falling edge
    // ------------------------------------------------------------------------

    task automatic wait_ready();
        int n;
        n = 0;
        if (cyc == trig_cyc) begin
            @(negedge ttc_clk); // last trigger still in flight, ready lags
        end
        while (acq_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge ttc_clk);
            n++;
        end
        check_true(acq_ready === 1'b1, "timeout waiting for acq_ready to rise");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (cac_state !== CAC_IDLE && n < WAIT_LIMIT) begin
            @(negedge ttc_clk);
            n++;
        end
        check_true(cac_state === CAC_IDLE, "timeout waiting for the controller to go idle");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || cac_state !== CAC_IDLE) && n < 4 * WAIT_LIMIT) begin
            @(negedge ttc_clk);
            n++;
        end
        check_true(exp_q.size() == 0, "timeout with events still expected from the fifo");
        repeat (4) @(negedge ttc_clk); // room for a stray write
        check_val("event_valid", event_valid, 0);
    endtask

    // trigger sampled at the next rising edge, returns one falling edge later
    task automatic send_trigger(input logic [TRIG_TYPE_W-1:0] ttype,
                                input logic [N_CHAN-1:0] en, input logic [DELAY_W-1:0] dly);
        wait_ready();
        trig_type   = ttype;
        chan_en     = en;   // held until the next trigger
        trig_delay  = dly;
        ttc_trigger = 1'b1;
        @(negedge ttc_clk);
        ttc_trigger = 1'b0;
        trig_cyc    = cyc;
        exp_num     = exp_num + 1'b1;
        exp_q.push_back(expected_event(exp_num, ttype));
        check_val("trig_num", trig_num, exp_num);
    endtask

    // ------------------------------------------------------------------------
    // channel model and event comparison
    // ------------------------------------------------------------------------

    always @(negedge ttc_clk) begin
        logic [31:0] r;
        for (int i = 0; i < N_CHAN; i++) begin
            if (!chan_enable[i]) begin
                chan_dones[i] = 1'b0; // drop with the enable
                done_wait[i]  = 0;
            end else if (chan_trig[i]) begin
                rand_bits(3, r);
                done_wait[i] = r[2:0] + 1; // 1 to 8 cycles
            end else if (done_wait[i] != 0) begin
                done_wait[i]--;
                if (done_wait[i] == 0) begin
                    chan_dones[i] = 1'b1;
                end
            end
        end
    end

    always @(posedge ttc_clk) begin
        logic [EVENT_W-1:0] exp_word;
        if (arst_n && event_valid && event_ready) begin // read at this edge
            check_true(exp_q.size() != 0, "fifo delivered an event that was never expected");
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                check_val("event_data", event_data, exp_word);
            end
        end
    end

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0]           r;
        logic [N_CHAN-1:0]     exp_trig;
        logic [TIMESTAMP_W-1:0] ts_first;
        longint                c_first;
        longint                c_rst;
        arst_n                = 1'b0;
        ttc_trigger           = 1'b0;
        trig_type             = '0;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        chan_en               = '0;
        trig_delay            = '0;
        event_ready           = 1'b1;
        repeat (RESET_CYC) @(negedge ttc_clk);
        arst_n = 1'b1;
        @(negedge ttc_clk);

        // values out of reset, counted with test 1
        check_val("acq_ready", acq_ready, 1);
        check_val("chan_trig", chan_trig, 0);
        check_val("chan_enable", chan_enable, 0);
        check_val("event_valid", event_valid, 0);
        check_val("error_trig_rate", error_trig_rate, 0);
        check_val("fifo_almost_full", fifo_almost_full, 0);
        check_val("trig_num", trig_num, 0);
        check_val("trig_timestamp", trig_timestamp, 0);
        check_val("cac_state", cac_state, CAC_IDLE);

        foreach (test_delays[i]) begin
            rand_bits(N_CHAN, r);
            send_trigger(TYPE_MUON_FILL, r[N_CHAN-1:0], DELAY_W'(test_delays[i]));
            for (int k = 1; k <= test_delays[i] + 3; k++) begin
                @(negedge ttc_clk); // state after edge N+k
                exp_trig = (k == test_delays[i] + 2) ? chan_en : '0;
                check_val("chan_trig", chan_trig, exp_trig);
                if (k == 1) begin
                    check_val("chan_enable", chan_enable, chan_en);
                end
            end
        end
        wait_drain();
        finish_test("chan_trig timing");

        for (int i = 0; i < 40; i++) begin
            rand_bits(TRIG_TYPE_W + N_CHAN + 4, r); // type, mask, delay 0..15
            send_trigger(r[TRIG_TYPE_W+N_CHAN+3:N_CHAN+4], r[N_CHAN+3:4], DELAY_W'(r[3:0]));
        end
        wait_drain();
        finish_test("trigger sequence");

        send_trigger(TYPE_LASER, '0, '0);
        ts_first = trig_timestamp;
        c_first  = trig_cyc;
        wait_ready();
        rand_bits(3, r);
        repeat (r[2:0]) @(negedge ttc_clk);
        send_trigger(TYPE_LASER, '0, '0);
        check_val("trig_timestamp delta", trig_timestamp - ts_first, trig_cyc - c_first);
        wait_ready();
        rst_trigger_timestamp = 1'b1;
        @(negedge ttc_clk);
        rst_trigger_timestamp = 1'b0;
        c_rst = cyc;               // counter is zero after this edge
        rand_bits(3, r);
        repeat (r[2:0]) @(negedge ttc_clk);
        send_trigger(TYPE_PEDESTAL, '0, '0);
        check_val("trig_timestamp", trig_timestamp, trig_cyc - c_rst - 1);
        wait_drain();
        finish_test("timestamp");

        check_val("error_trig_rate", error_trig_rate, 0);
        send_trigger(TYPE_MUON_FILL, '1, DELAY_W'(MAX_DELAY));
        @(negedge ttc_clk);
        check_val("acq_ready", acq_ready, 0); // delay running
        ttc_trigger = 1'b1;
        @(negedge ttc_clk);
        ttc_trigger = 1'b0;
        check_val("trig_num", trig_num, exp_num);
        check_val("error_trig_rate", error_trig_rate, 1);
        wait_drain();
        finish_test("trigger while busy");

        event_ready = 1'b0; // let the fifo fill
        for (int i = 0; i < FIFO_AF_LEVEL; i++) begin
            wait_ready();
            check_val("fifo_almost_full", fifo_almost_full, 0);
            rand_bits(TRIG_TYPE_W + N_CHAN + 2, r);
            send_trigger(r[TRIG_TYPE_W+N_CHAN+1:N_CHAN+2], r[N_CHAN+1:2], DELAY_W'(r[1:0]));
        end
        @(negedge ttc_clk);
        wait_idle();
        check_val("fifo_almost_full", fifo_almost_full, 1);
        check_val("acq_ready", acq_ready, 0);
        event_ready = 1'b1;
        wait_drain();
        check_val("fifo_almost_full", fifo_almost_full, 0);
        finish_test("fifo back-pressure");

        wait_ready();
        rst_trigger_num = 1'b1;
        @(negedge ttc_clk);
        rst_trigger_num = 1'b0;
        check_val("trig_num", trig_num, 0);
        exp_num = '0; // next accepted trigger is 1
        send_trigger(TYPE_PEDESTAL, '1, DELAY_W'(3));
        wait_drain();
        finish_test("trigger number reset");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 test_no, tests_failed, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run length bound, worst case per trigger plus margin
    initial begin
        #(WATCHDOG_CYC * 2 * CLK_HALF);
        $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- design/trigger_top.sv
// ttc_clk only; chan_en and trig_delay are sampled per trigger and must be stable around it
`timescale 1ns/100ps

module trigger_top
    import trig_pkg::*;
    import acq_pkg::*;
(
    input  logic                   ttc_clk,
    input  logic                   arst_n,
    input  logic                   ttc_trigger,
    input  logic [TRIG_TYPE_W-1:0] trig_type,
    input  logic                   rst_trigger_num,       // ttc channel b
    input  logic                   rst_trigger_timestamp, // ttc channel b
    input  logic [N_CHAN-1:0]      chan_en,
    input  logic [DELAY_W-1:0]     trig_delay,
    input  logic [N_CHAN-1:0]      chan_dones,
    input  logic                   event_ready,
    output logic [N_CHAN-1:0]      chan_enable,
    output logic [N_CHAN-1:0]      chan_trig,
    output logic [TRIG_NUM_W-1:0]  trig_num,
    output logic [TIMESTAMP_W-1:0] trig_timestamp,
    output logic                   acq_ready,
    output logic                   error_trig_rate,
    output logic                   event_valid,
    output logic [EVENT_W-1:0]     event_data,
    output logic                   fifo_almost_full,
    output logic [CAC_STATE_W-1:0] cac_state
);

    // controller to fifo write side
    logic               wr_valid;
    logic               wr_ready;
    logic [EVENT_W-1:0] wr_data;

    acq_if acq_bus (); // receiver to controller

    assign acq_ready = acq_bus.ready;

    // ------------------------------------------------------------------------
    // instances
    // ------------------------------------------------------------------------

    ttc_trigger_receiver i_ttc_trigger_receiver (
        .ttc_clk               (ttc_clk),
        .arst_n                (arst_n),
        .ttc_trigger           (ttc_trigger),
        .trig_type             (trig_type),
        .rst_trigger_num       (rst_trigger_num),
        .rst_trigger_timestamp (rst_trigger_timestamp),
        .trig_num              (trig_num),
        .trig_timestamp        (trig_timestamp),
        .error_trig_rate       (error_trig_rate),
        .acq                   (acq_bus.rx)
    );

    channel_acq_controller i_channel_acq_controller (
        .ttc_clk          (ttc_clk),
        .arst_n           (arst_n),
        .chan_en          (chan_en),
        .trig_delay       (trig_delay),
        .chan_dones       (chan_dones),
        .wr_ready         (wr_ready),
        .fifo_almost_full (fifo_almost_full),
        .acq              (acq_bus.ctl),
        .chan_enable      (chan_enable),
        .chan_trig        (chan_trig),
        .wr_valid         (wr_valid),
        .wr_data          (wr_data),
        .cac_state        (cac_state)
    );

    acq_event_fifo i_acq_event_fifo (
        .ttc_clk          (ttc_clk),
        .arst_n           (arst_n),
        .wr_valid         (wr_valid),
        .wr_data          (wr_data),
        .event_ready      (event_ready),
        .wr_ready         (wr_ready),
        .event_valid      (event_valid),
        .event_data       (event_data),
        .fifo_almost_full (fifo_almost_full)
    );

endmodule

//--- design/acq_event_fifo.sv
// single clock fwft fifo; head word shows one cycle after its write, no read-through when empty
`timescale 1ns/100ps

module acq_event_fifo
    import acq_pkg::*;
(
    input  logic               ttc_clk,
    input  logic               arst_n,
    input  logic               wr_valid,
    input  logic [EVENT_W-1:0] wr_data,
    input  logic               event_ready,
    output logic               wr_ready,         // not full
    output logic               event_valid,      // not empty
    output logic [EVENT_W-1:0] event_data,       // head word
    output logic               fifo_almost_full
);

    logic [EVENT_W-1:0]    mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fill;
    logic                  do_wr;
    logic                  do_rd;

    assign wr_ready         = (fill != FIFO_CNT_W'(FIFO_DEPTH));
    assign event_valid      = (fill != '0);
    assign event_data       = mem[rd_ptr];
    assign fifo_almost_full = (fill >= FIFO_CNT_W'(FIFO_AF_LEVEL));

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = event_valid && event_ready;

    // storage
    always_ff @(posedge ttc_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill; // none or both
            endcase
        end
    end

    a_fill_bound : assert property (
        @(posedge ttc_clk) disable iff (!arst_n)
        fill <= FIFO_CNT_W'(FIFO_DEPTH)
    );

endmodule

//--- design/channel_acq_controller.sv
// chan_dones may be asynchronous; done lines must drop within 2 cycles of chan_enable dropping
`timescale 1ns/100ps

module channel_acq_controller
    import trig_pkg::*;
    import acq_pkg::*;
(
    input  logic                   ttc_clk,
    input  logic                   arst_n,
    input  logic [N_CHAN-1:0]      chan_en,          // channel mask, latched per trigger
    input  logic [DELAY_W-1:0]     trig_delay,       // cycles before chan_trig
    input  logic [N_CHAN-1:0]      chan_dones,       // from channel fpgas
    input  logic                   wr_ready,         // fifo not full
    input  logic                   fifo_almost_full,
    acq_if.ctl                     acq,
    output logic [N_CHAN-1:0]      chan_enable,
    output logic [N_CHAN-1:0]      chan_trig,
    output logic                   wr_valid,
    output logic [EVENT_W-1:0]     wr_data,
    output logic [CAC_STATE_W-1:0] cac_state
);

    logic [CAC_STATE_W-1:0] state;
    logic                   timer_start;
    logic                   timer_expired;
    logic [N_CHAN-1:0]      dones_meta;  // first sync stage
    logic [N_CHAN-1:0]      dones_sync;  // second sync stage
    logic                   all_done;
    logic [TRIG_NUM_W-1:0]  num_q;
    logic [TRIG_TYPE_W-1:0] type_q;

    // triggers only arrive in idle, the receiver saw ready first
    assign timer_start = (state == CAC_IDLE) && acq.trigger;
    assign all_done    = ((dones_sync & chan_enable) == chan_enable); // empty mask passes
    assign acq.ready   = (state == CAC_IDLE) && !fifo_almost_full;
    assign cac_state   = state;

    acq_delay_timer i_acq_delay_timer (
        .ttc_clk    (ttc_clk),
        .arst_n     (arst_n),
        .start      (timer_start),
        .load_value (trig_delay),
        .expired    (timer_expired)
    );

    // ------------------------------------------------------------------------
    // done line synchronizer
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            dones_meta <= '0;
            dones_sync <= '0;
        end else begin
            dones_meta <= chan_dones;
            dones_sync <= dones_meta;
        end
    end

    // ------------------------------------------------------------------------
    // acquisition fsm
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= CAC_IDLE;
            chan_enable <= '0;
            chan_trig   <= '0;
            wr_valid    <= 1'b0;
        end else begin
            chan_trig <= '0; // pulse lasts one cycle
            case (state)
                CAC_IDLE: begin
                    if (acq.trigger) begin
                        chan_enable <= chan_en;
                        state       <= CAC_DELAY;
                    end
                end
                CAC_DELAY: begin
                    if (timer_expired) begin
                        chan_trig <= chan_enable; // enabled channels only
                        state     <= CAC_ARM;
                    end
                end
                CAC_ARM: begin
                    state <= CAC_WAIT;
                end
                CAC_WAIT: begin
                    if (all_done) begin
                        wr_valid <= 1'b1;
                        state    <= CAC_WRITE;
                    end
                end
                CAC_WRITE: begin
                    if (wr_ready) begin // event taken by fifo
                        wr_valid    <= 1'b0;
                        chan_enable <= '0;
                        state       <= CAC_IDLE;
                    end
                end
                default: begin
                    state <= CAC_IDLE;
                end
            endcase
        end
    end

    // number and type of the event in flight
    always_ff @(posedge ttc_clk) begin
        if (timer_start) begin
            num_q  <= acq.trig_num;
            type_q <= acq.trig_type;
        end
    end

    // event word, reserved bits stay zero
    always_comb begin
        wr_data = '0;
        wr_data[EVT_NUM_LSB +: TRIG_NUM_W]   = num_q;
        wr_data[EVT_TYPE_LSB +: TRIG_TYPE_W] = type_q;
    end

    // mask used for the pulse must match the one shown to the channels
    a_trig_in_mask : assert property (
        @(posedge ttc_clk) disable iff (!arst_n)
        (chan_trig & ~chan_enable) == '0
    );

    a_valid_in_write : assert property (
        @(posedge ttc_clk) disable iff (!arst_n)
        wr_valid |-> (state == CAC_WRITE)
    );

endmodule

//--- design/acq_delay_timer.sv
// delay in ttc_clk cycles; a start while running reloads, expired follows start by load_value+1
`timescale 1ns/100ps

module acq_delay_timer
    import acq_pkg::*;
(
    input  logic               ttc_clk,
    input  logic               arst_n,
    input  logic               start,      // one-cycle load strobe
    input  logic [DELAY_W-1:0] load_value, // delay in cycles
    output logic               expired     // one-cycle pulse
);

    logic [DELAY_W-1:0] count;
    logic               running; // held through the expired cycle

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            running <= 1'b0;
            expired <= 1'b0;
        end else if (start) begin
            count   <= load_value;
            running <= 1'b1;
            expired <= (load_value == '0); // zero delay fires next cycle
        end else begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
            if (expired) begin
                running <= 1'b0; // done after the pulse
            end
            expired <= running && (count == DELAY_W'(1)); // look one ahead
        end
    end

    // pulse only comes out of an active count
    a_expired_running : assert property (
        @(posedge ttc_clk) disable iff (!arst_n)
        expired |-> running
    );

endmodule

//--- design/ttc_trigger_receiver.sv
// ttc_trigger must be synchronous to ttc_clk; one trigger per busy window, others are errors
`timescale 1ns/100ps

module ttc_trigger_receiver
    import trig_pkg::*;
(
    input  logic                   ttc_clk,
    input  logic                   arst_n,
    input  logic                   ttc_trigger,           // from ttc decoder
    input  logic [TRIG_TYPE_W-1:0] trig_type,
    input  logic                   rst_trigger_num,       // channel b command
    input  logic                   rst_trigger_timestamp, // channel b command
    output logic [TRIG_NUM_W-1:0]  trig_num,              // number of last accepted trigger
    output logic [TIMESTAMP_W-1:0] trig_timestamp,        // time of last accepted trigger
    output logic                   error_trig_rate,       // sticky until arst_n
    acq_if.rx                      acq
);

    logic [TIMESTAMP_W-1:0] ts_cnt;     // free running
    logic                   trig_pulse; // drives acq trigger
    logic [TRIG_TYPE_W-1:0] type_q;
    logic                   accept;

    // no accept while a pulse is still in flight, ready lags by one cycle
    assign accept = ttc_trigger && acq.ready && !trig_pulse;

    assign acq.trigger   = trig_pulse;
    assign acq.trig_type = type_q;
    assign acq.trig_num  = trig_num;

    // ------------------------------------------------------------------------
    // timestamp counter
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            ts_cnt <= '0;
        end else if (rst_trigger_timestamp) begin
            ts_cnt <= '0; // restart from channel b
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // trigger number, capture and rate error
    // ------------------------------------------------------------------------

    always_ff @(posedge ttc_clk or negedge arst_n) begin
        if (!arst_n) begin
            trig_num        <= '0;
            trig_timestamp  <= '0;
            trig_pulse      <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            trig_pulse <= accept;
            if (accept) begin
                // a reset in the same cycle makes this trigger number 1
                trig_num       <= rst_trigger_num ? TRIG_NUM_W'(1) : trig_num + 1'b1;
                trig_timestamp <= ts_cnt;
            end else if (rst_trigger_num) begin
                trig_num <= '0;
            end
            if (ttc_trigger && !accept) begin
                error_trig_rate <= 1'b1; // path was busy
            end
        end
    end

    // type is payload, only meaningful alongside the pulse
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            type_q <= trig_type;
        end
    end

    // back-to-back triggers must never merge into a long pulse
    a_trig_pulse_single : assert property (
        @(posedge ttc_clk) disable iff (!arst_n)
        acq.trigger |=> !acq.trigger
    );

endmodule

//--- design/acq_if.sv
// single ttc_clk domain; trig_type and trig_num stay valid until the next accepted trigger
`timescale 1ns/100ps

interface acq_if
    import trig_pkg::*;
();

    logic                   trigger;   // one-cycle pulse per accepted trigger
    logic [TRIG_TYPE_W-1:0] trig_type; // held from the pulse on
    logic [TRIG_NUM_W-1:0]  trig_num;  // held from the pulse on
    logic                   ready;     // level, controller idle and fifo has room

    // receiver side
    modport rx (output trigger, output trig_type, output trig_num, input ready);

    // channel acquisition controller side
    modport ctl (input trigger, input trig_type, input trig_num, output ready);

endinterface

//--- design/acq_pkg.sv
// acquisition sizes and event layout; FIFO_DEPTH must stay a power of two for pointer wrap
package acq_pkg;

    // ------------------------------------------------------------------------
    // channel side
    // ------------------------------------------------------------------------

    localparam int N_CHAN  = 5;  // channel fpgas behind this controller
    localparam int DELAY_W = 16; // trigger delay in ttc_clk cycles

    // ------------------------------------------------------------------------
    // acquisition event fifo
    // ------------------------------------------------------------------------

    localparam int EVENT_W       = 32;
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_AF_LEVEL = 15;                       // almost full at this fill
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);   // counts 0..FIFO_DEPTH

    // event word: [23:0] trigger number, [28:24] trigger type, [31:29] reserved zero
    localparam int EVT_NUM_LSB  = 0;
    localparam int EVT_TYPE_LSB = 24;

    // ------------------------------------------------------------------------
    // controller state codes, shown on cac_state
    // ------------------------------------------------------------------------

    localparam int CAC_STATE_W = 3;

    localparam logic [CAC_STATE_W-1:0] CAC_IDLE  = 3'd0; // waiting for a trigger
    localparam logic [CAC_STATE_W-1:0] CAC_DELAY = 3'd1; // trigger delay running
    localparam logic [CAC_STATE_W-1:0] CAC_ARM   = 3'd2; // chan_trig pulse out
    localparam logic [CAC_STATE_W-1:0] CAC_WAIT  = 3'd3; // waiting on done lines
    localparam logic [CAC_STATE_W-1:0] CAC_WRITE = 3'd4; // event word to fifo

endpackage

//--- design/trig_pkg.sv
// trigger widths and type codes; type codes are labels only, the datapath treats them alike
package trig_pkg;

    // ------------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------------

    localparam int TRIG_NUM_W  = 24; // global trigger number, first trigger is 1
    localparam int TIMESTAMP_W = 44; // ttc_clk ticks since last timestamp reset
    localparam int TRIG_TYPE_W = 5;

    // ------------------------------------------------------------------------
    // trigger type codes
    // ------------------------------------------------------------------------

    // one code per type word
    localparam logic [TRIG_TYPE_W-1:0] TYPE_MUON_FILL = 5'd1;
    localparam logic [TRIG_TYPE_W-1:0] TYPE_LASER     = 5'd2;
    localparam logic [TRIG_TYPE_W-1:0] TYPE_PEDESTAL  = 5'd3;

endpackage
